// ==== compile.f ====
nandOutputPkg.sv
nandCommandLatch.sv
nandWordFetch.sv
nandByteCycle.sv
nandDataOutput.sv
tbNandDataOutput.sv

// ==== Makefile ====
# Verilator build and run for the NAND data output engine

VERILATOR ?= verilator
TOP ?= tbNandDataOutput
FILE_LIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
SIM ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tbNandDataOutput.sv ====
`timescale 1ns/1ps

module tbNandDataOutput;

    localparam int NumberOfWays = 4;
    localparam int SetupCycles = nandOutputPkg::DefaultSetupCycles;
    localparam int SlotCycles = nandOutputPkg::DefaultSlotCycles;
    localparam int WeLowCycles = nandOutputPkg::DefaultWeLowCycles;
    localparam int ClockPeriod = 10;
    localparam int ResetCycles = 10;
    localparam int NumSessions = 20;
    localparam int TimeoutCycles = NumSessions * (SetupCycles + 9 * SlotCycles + 40);

    logic iSystemClock;
    logic iReset;
    logic iStart;
    logic [NumberOfWays-1:0] iTargetWay;
    nandOutputPkg::byteCount_t iNumOfData;
    nandOutputPkg::hostWord_t iWriteData;
    logic iWriteValid;
    logic oWriteReady;
    logic oReady;
    logic oLastStep;
    logic [2*NumberOfWays-1:0] oChipEnable;
    logic oWriteEnable;
    nandOutputPkg::busByte_t oData;

    nandOutputPkg::busByte_t expectQ[$]; // bytes the flash should see, in order
    nandOutputPkg::hostWord_t wordQ[$];
    logic [NumberOfWays-1:0] sessionMask = '0;
    int seed;
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    int cycle = 0;
    int ceRiseCycle = 0;
    int weLowRun = 0;
    int bytesSeen = 0;
    int lastStepSeen = 0;
    logic firstFallSeen = 1'b0;
    logic readyCheckDue = 1'b0;
    logic monitorOn = 1'b0;
    logic prevWe = 1'b1;
    logic [2*NumberOfWays-1:0] prevCe = '0;

    nandDataOutput i_nandDataOutput (
        .iSystemClock(iSystemClock),
        .iReset(iReset),
        .iStart(iStart),
        .iTargetWay(iTargetWay),
        .iNumOfData(iNumOfData),
        .iWriteData(iWriteData),
        .iWriteValid(iWriteValid),
        .oWriteReady(oWriteReady),
        .oReady(oReady),
        .oLastStep(oLastStep),
        .oChipEnable(oChipEnable),
        .oWriteEnable(oWriteEnable),
        .oData(oData)
    );

    initial iSystemClock = 1'b0;
    always #(ClockPeriod / 2) iSystemClock = ~iSystemClock;

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAIL %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        errorCount++;
    endtask

    task automatic reportProblem(input string what);
        $display("error: %s", what);
        errorCount++;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("%s: passed", name);
        end else begin
            failCount++;
            $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // all checks sample in the middle of the cycle
    always @(negedge iSystemClock) begin
        nandOutputPkg::busByte_t expected;
        cycle = cycle + 1;
        if (monitorOn) begin
            if (prevCe == '0 && oChipEnable != '0) begin
                ceRiseCycle = cycle; // new session selected
                firstFallSeen = 1'b0;
            end
            if (!oWriteEnable) begin
                weLowRun = weLowRun + 1;
                if (oChipEnable !== {sessionMask, sessionMask}) begin
                    reportMismatch("oChipEnable", {sessionMask, sessionMask}, oChipEnable);
                end
            end
            if (prevWe && !oWriteEnable) begin
                if (!firstFallSeen) begin
                    firstFallSeen = 1'b1;
                    if (cycle - ceRiseCycle < SetupCycles + 1) begin
                        reportProblem("write enable fell before the chip select setup time");
                    end
                end
                if (expectQ.size() == 0) begin
                    reportProblem("write enable pulse with no byte pending");
                end
            end
            if (!prevWe && oWriteEnable) begin // flash latches here
                bytesSeen++;
                if (weLowRun != WeLowCycles) begin
                    reportMismatch("oWriteEnable low cycles", WeLowCycles, weLowRun);
                end
                if (expectQ.size() == 0) begin
                    reportProblem("byte written beyond the session count");
                end else begin
                    expected = expectQ.pop_front();
                    if (oData !== expected) begin
                        reportMismatch("oData", expected, oData);
                    end
                end
            end
            if (oWriteEnable) begin
                weLowRun = 0;
            end
            if (readyCheckDue) begin
                readyCheckDue = 1'b0;
                if (oReady !== 1'b1) begin
                    reportMismatch("oReady", 1, oReady);
                end
            end
            if (oLastStep) begin
                lastStepSeen++;
                readyCheckDue = 1'b1;
                if (expectQ.size() != 0 || !oWriteEnable) begin
                    reportProblem("last step came before the final byte was written");
                end
                if (oChipEnable !== '0) begin
                    reportMismatch("oChipEnable", 0, oChipEnable);
                end
            end
        end
        prevWe = oWriteEnable;
        prevCe = oChipEnable;
    end

    task automatic sendWord(input nandOutputPkg::hostWord_t word);
        logic accepted;
        accepted = 1'b0;
        iWriteValid = 1'b1;
        iWriteData = word;
        while (!accepted) begin
            @(negedge iSystemClock);
            accepted = oWriteReady; // transfer on the coming edge
            @(posedge iSystemClock);
            #1;
        end
        iWriteValid = 1'b0;
    endtask

    task automatic driveWords();
        int gap;
        while (wordQ.size() != 0) begin
            gap = {$random(seed)} % 4;
            while (oWriteReady !== 1'b1) begin
                @(posedge iSystemClock);
                #1;
            end
            repeat (gap) begin // host idles while the fetch stage has room
                @(posedge iSystemClock);
                #1;
            end
            sendWord(wordQ.pop_front());
        end
    endtask

    task automatic checkResetValues();
        int errorsBefore;
        errorsBefore = errorCount;
        @(negedge iSystemClock);
        if (oReady !== 1'b1) reportMismatch("oReady", 1, oReady);
        if (oChipEnable !== '0) reportMismatch("oChipEnable", 0, oChipEnable);
        if (oWriteEnable !== 1'b1) reportMismatch("oWriteEnable", 1, oWriteEnable);
        if (oWriteReady !== 1'b0) reportMismatch("oWriteReady", 0, oWriteReady);
        if (oLastStep !== 1'b0) reportMismatch("oLastStep", 0, oLastStep);
        finishTest("reset values", errorsBefore);
    endtask

    task automatic runSession(input int index);
        int count;
        int errorsBefore;
        int bytesBefore;
        int lastBefore;
        logic [31:0] randomBits;
        logic [NumberOfWays-1:0] mask;
        nandOutputPkg::hostWord_t word;
        randomBits = {$random(seed)} % ((1 << NumberOfWays) - 1) + 1; // never an empty mask
        mask = randomBits[NumberOfWays-1:0];
        count = {$random(seed)} % 9 + 1;
        for (int w = 0; w < (count + 1) / 2; w++) begin
            randomBits = $random(seed);
            word = randomBits[15:0];
            wordQ.push_back(word);
            expectQ.push_back(word.upperByte);
            if (2 * w + 1 < count) begin
                expectQ.push_back(word.lowerByte); // odd count drops the last lower byte
            end
        end
        errorsBefore = errorCount;
        bytesBefore = bytesSeen;
        lastBefore = lastStepSeen;
        sessionMask = mask;
        @(posedge iSystemClock);
        #1;
        iStart = 1'b1;
        iTargetWay = mask;
        iNumOfData = nandOutputPkg::byteCount_t'(count);
        @(posedge iSystemClock);
        #1;
        iStart = 1'b0;
        fork
            driveWords();
            begin
                do @(negedge iSystemClock); while (oLastStep !== 1'b1);
            end
        join
        repeat (3) @(negedge iSystemClock); // catch a repeated last step
        if (lastStepSeen - lastBefore != 1) begin
            reportProblem($sformatf("saw %0d last step pulses instead of one",
                                    lastStepSeen - lastBefore));
        end
        if (bytesSeen - bytesBefore != count) begin
            reportMismatch("byte count", count, bytesSeen - bytesBefore);
        end
        finishTest($sformatf("session %0d ways 0x%0h bytes %0d", index, mask, count),
                   errorsBefore);
    endtask

    initial begin
        seed = 10680;
        iReset = 1'b1;
        iStart = 1'b0;
        iTargetWay = '0;
        iNumOfData = '0;
        iWriteData = '0;
        iWriteValid = 1'b0;
        repeat (ResetCycles) @(posedge iSystemClock);
        #1;
        iReset = 1'b0;
        checkResetValues();
        monitorOn = 1'b1;
        for (int s = 1; s <= NumSessions; s++) begin
            runSession(s);
        end
        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((ResetCycles + TimeoutCycles) * ClockPeriod);
        $display("timeout: sessions did not finish within %0d cycles", TimeoutCycles);
        $display("tests passed: %0d, tests failed: %0d", passCount, failCount + 1);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== nandDataOutput.sv ====
`timescale 1ns/1ps

module nandDataOutput #(
    parameter int NumberOfWays = 4,
    parameter int SetupCycles = nandOutputPkg::DefaultSetupCycles,
    parameter int SlotCycles = nandOutputPkg::DefaultSlotCycles,
    parameter int WeLowCycles = nandOutputPkg::DefaultWeLowCycles // below SlotCycles
) (
    input  logic                        iSystemClock,
    input  logic                        iReset,
    input  logic                        iStart,
    input  logic [NumberOfWays-1:0]     iTargetWay,
    input  nandOutputPkg::byteCount_t   iNumOfData,
    input  nandOutputPkg::hostWord_t    iWriteData,
    input  logic                        iWriteValid,
    output logic                        oWriteReady,
    output logic                        oReady,
    output logic                        oLastStep,
    output logic [2*NumberOfWays-1:0]   oChipEnable,
    output logic                        oWriteEnable,
    output nandOutputPkg::busByte_t     oData
);

    logic sessionGo;
    logic sessionDone;
    logic sessionActive;
    nandOutputPkg::sessionCmd_t sessionCmd;
    logic byteValid;
    logic byteTake;
    nandOutputPkg::busByte_t nextByte;

    nandCommandLatch #(
        .NumberOfWays(NumberOfWays),
        .SetupCycles(SetupCycles)
    ) i_nandCommandLatch (
        .iSystemClock(iSystemClock),
        .iReset(iReset),
        .iStart(iStart),
        .iTargetWay(iTargetWay),
        .iNumOfData(iNumOfData),
        .sessionDone(sessionDone),
        .oReady(oReady),
        .oChipEnable(oChipEnable),
        .sessionActive(sessionActive),
        .sessionGo(sessionGo),
        .sessionCmd(sessionCmd)
    );

    nandWordFetch i_nandWordFetch (
        .iSystemClock(iSystemClock),
        .iReset(iReset),
        .sessionActive(sessionActive),
        .iWriteData(iWriteData),
        .iWriteValid(iWriteValid),
        .oWriteReady(oWriteReady),
        .byteTake(byteTake),
        .byteValid(byteValid),
        .nextByte(nextByte)
    );

    nandByteCycle #(
        .SlotCycles(SlotCycles),
        .WeLowCycles(WeLowCycles)
    ) i_nandByteCycle (
        .iSystemClock(iSystemClock),
        .iReset(iReset),
        .sessionGo(sessionGo),
        .sessionCmd(sessionCmd),
        .byteValid(byteValid),
        .nextByte(nextByte),
        .byteTake(byteTake),
        .oData(oData),
        .oWriteEnable(oWriteEnable),
        .oLastStep(oLastStep),
        .sessionDone(sessionDone)
    );

endmodule

// ==== nandByteCycle.sv ====
`timescale 1ns/1ps

module nandByteCycle #(
    parameter int SlotCycles = 10,
    parameter int WeLowCycles = 5
) (
    input  logic                        iSystemClock,
    input  logic                        iReset,
    input  logic                        sessionGo,
    input  nandOutputPkg::sessionCmd_t  sessionCmd,
    input  logic                        byteValid,
    input  nandOutputPkg::busByte_t     nextByte,
    output logic                        byteTake,
    output nandOutputPkg::busByte_t     oData,
    output logic                        oWriteEnable,
    output logic                        oLastStep,
    output logic                        sessionDone
);

    localparam int TimerWidth = $clog2(SlotCycles + 1);

    nandOutputPkg::byteCount_t remaining;
    nandOutputPkg::byteCount_t available;
    logic [TimerWidth-1:0] slotTimer;
    logic slotBusy;
    logic slotEnd;
    logic startSlot;
    logic weRelease;
    logic lastStep;

    // count is not loaded yet in the go cycle
    assign available = sessionGo ? sessionCmd.byteCount : remaining;

    assign slotEnd = slotBusy && (slotTimer == TimerWidth'(SlotCycles - 1));
    assign startSlot = (available != '0) && byteValid && (!slotBusy || slotEnd);
    assign weRelease = slotBusy && (slotTimer == TimerWidth'(WeLowCycles - 1));

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            remaining <= '0;
            slotTimer <= '0;
            slotBusy <= 1'b0;
            byteTake <= 1'b0;
            oWriteEnable <= 1'b1;
            lastStep <= 1'b0;
        end else begin
            byteTake <= startSlot; // first cycle of the slot
            lastStep <= slotEnd && (remaining == '0);
            if (startSlot) begin
                remaining <= nandOutputPkg::byteCount_t'(available - 1'b1);
                slotBusy <= 1'b1;
                slotTimer <= '0;
                oWriteEnable <= 1'b0;
            end else begin
                if (sessionGo) begin
                    remaining <= sessionCmd.byteCount;
                end
                if (slotEnd) begin
                    slotBusy <= 1'b0; // bus idles until a byte shows up
                end
                if (slotBusy) begin
                    slotTimer <= slotTimer + 1'b1;
                end
                if (weRelease) begin
                    oWriteEnable <= 1'b1; // flash latches on this edge
                end
            end
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (startSlot) begin
            oData <= nextByte; // held until the next slot
        end
    end

    assign oLastStep = lastStep;
    assign sessionDone = lastStep;

    weLowOnlyInSlot: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        !oWriteEnable |-> slotBusy && (slotTimer < TimerWidth'(WeLowCycles))
    ) else $error("write enable low outside the pulse window of a slot");

endmodule

// ==== nandWordFetch.sv ====
`timescale 1ns/1ps

module nandWordFetch (
    input  logic                        iSystemClock,
    input  logic                        iReset,
    input  logic                        sessionActive,
    input  nandOutputPkg::hostWord_t    iWriteData,
    input  logic                        iWriteValid,
    output logic                        oWriteReady,
    input  logic                        byteTake,
    output logic                        byteValid,
    output nandOutputPkg::busByte_t     nextByte
);

    nandOutputPkg::hostWord_t wordHold;
    logic wordFull;
    logic lowerHalf; // upper byte goes first
    logic wordAccepted;

    assign oWriteReady = sessionActive && !wordFull;
    assign wordAccepted = oWriteReady && iWriteValid;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            wordFull <= 1'b0;
            lowerHalf <= 1'b0;
        end else if (!sessionActive) begin
            wordFull <= 1'b0; // drop a leftover lower byte
            lowerHalf <= 1'b0;
        end else if (wordAccepted) begin
            wordFull <= 1'b1;
            lowerHalf <= 1'b0;
        end else if (byteTake) begin
            if (lowerHalf) begin
                wordFull <= 1'b0; // free for the next word
                lowerHalf <= 1'b0;
            end else begin
                lowerHalf <= 1'b1;
            end
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (wordAccepted) begin
            wordHold <= iWriteData;
        end
    end

    assign byteValid = wordFull;
    assign nextByte = lowerHalf ? wordHold.lowerByte : wordHold.upperByte;

    takeOnlyWhenValid: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        byteTake |-> byteValid
    ) else $error("byte taken while none is offered");

endmodule

// ==== nandCommandLatch.sv ====
`timescale 1ns/1ps

module nandCommandLatch #(
    parameter int NumberOfWays = 4,
    parameter int SetupCycles = 10
) (
    input  logic                              iSystemClock,
    input  logic                              iReset,
    input  logic                              iStart,
    input  logic [NumberOfWays-1:0]           iTargetWay,
    input  nandOutputPkg::byteCount_t         iNumOfData,
    input  logic                              sessionDone,
    output logic                              oReady,
    output logic [2*NumberOfWays-1:0]         oChipEnable,
    output logic                              sessionActive,
    output logic                              sessionGo,
    output nandOutputPkg::sessionCmd_t        sessionCmd
);

    localparam int TimerWidth = $clog2(SetupCycles + 1);

    typedef enum logic [1:0] {
        stateIdle,
        stateSetup,
        stateTransfer
    } latchState_t;

    latchState_t state;
    logic [TimerWidth-1:0] setupTimer;
    logic [NumberOfWays-1:0] wayMask;
    logic startAccepted;
    logic setupDone;

    assign startAccepted = iStart && (state == stateIdle);
    assign setupDone = (state == stateSetup) && (setupTimer == TimerWidth'(SetupCycles - 1));

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= stateIdle;
            setupTimer <= '0;
            sessionGo <= 1'b0;
        end else begin
            sessionGo <= 1'b0;
            case (state)
                stateIdle: begin
                    setupTimer <= '0;
                    if (startAccepted) begin
                        state <= stateSetup;
                    end
                end
                stateSetup: begin
                    setupTimer <= setupTimer + 1'b1;
                    if (setupDone) begin
                        state <= stateTransfer;
                        sessionGo <= 1'b1; // CE held for SetupCycles
                    end
                end
                stateTransfer: begin
                    if (sessionDone) begin
                        state <= stateIdle;
                    end
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (startAccepted) begin
            wayMask <= iTargetWay;
            sessionCmd.byteCount <= iNumOfData;
        end
    end

    assign oReady = (state == stateIdle);

    // CE drops in the same cycle as the done pulse
    assign sessionActive = (state != stateIdle) && !sessionDone;
    assign oChipEnable = sessionActive ? {wayMask, wayMask} : '0; // both lanes

    zeroCountNeverAccepted: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        startAccepted |-> (iNumOfData != '0)
    ) else $error("start accepted with a zero byte count");

endmodule

// ==== nandOutputPkg.sv ====
package nandOutputPkg;

    // byte count of one write session
    typedef logic [15:0] byteCount_t;

    // one byte on the flash DQ bus
    typedef logic [7:0] busByte_t;

    // host word, upper byte goes out first
    typedef struct packed {
        busByte_t upperByte;
        busByte_t lowerByte;
    } hostWord_t;

    // handed from the latch stage to the byte stage
    typedef struct packed {
        byteCount_t byteCount;
    } sessionCmd_t;

    // default timing in system clocks
    parameter int DefaultSetupCycles = 10; // tCS
    parameter int DefaultSlotCycles = 10;  // one byte per slot
    parameter int DefaultWeLowCycles = 5;  // tWP

endpackage
